/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build cache_tb with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --assert -Wno-fatal --top-module cache_tb -f sim.f -Mdir obj_dir -o cache_tb
	./obj_dir/cache_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "test failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" sim.log; then echo "test did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* dv/cache_tb.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb
	import cache_pkg::*;
();

	localparam int HALF_PERIOD = 10; // 20 ns clock
	localparam int RESET_CYCLES = 5;
	localparam int RANDOM_OPS = 200;
	localparam int MAX_CYCLES = RANDOM_OPS * 15 + 1000; // worst op is 15 cycles plus margin
	localparam int FILL_CYCLES = 1 + `CACHE_WORDS + `CACHE_MEM_LATENCY; // miss seen to stall low
	localparam int FILL_GUARD = FILL_CYCLES + 8; // loop bound if stall never falls
	localparam int WORDS = 1 << (`CACHE_ADDR_W - 1);
	localparam int SETS = 1 << `CACHE_INDEX_W;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003; // x^32+x^22+x^2+x+1

	logic clk;
	logic rst;
	cache_req_t req;
	mem_rsp_t mem_rsp;
	mem_req_t mem_req;
	logic [`CACHE_DATA_W-1:0] rdata;
	logic hit;
	logic stall;

	logic [`CACHE_DATA_W-1:0] shadow [WORDS]; // expected memory words
	logic [SETS-1:0] model_valid; // expected valid bits of the direct mapped cache
	logic [`CACHE_TAG_W-1:0] model_tag [SETS];
	logic [31:0] lfsr;
	int cycle_count;
	int writes_seen; // write-through strobes on the memory port
	int writes_expected;
	int checks;
	int mismatches;
	int other_errors;

	cache_top u_cache_top (
		.clk(clk),
		.rst(rst),
		.req(req),
		.mem_rsp(mem_rsp),
		.rdata(rdata),
		.hit(hit),
		.stall(stall),
		.mem_req(mem_req)
	);

	mem_model u_mem (
		.clk(clk),
		.rst(rst),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run still going after %0d cycles", MAX_CYCLES);
			print_counts();
			$display("Result: FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (!rst && mem_req.write) begin
			writes_seen <= writes_seen + 1;
		end
	end

	// memory reads belong to a fill, and a fill stalls the pipeline
	a_read_in_fill: assert property (@(posedge clk) disable iff (rst) mem_req.read |-> stall)
		else protocol_error("memory read issued while the pipeline was not stalled");
	a_no_write_in_fill: assert property (@(posedge clk) disable iff (rst) stall |-> !mem_req.write)
		else protocol_error("write-through issued before the fill finished");
	a_hit_no_stall: assert property (@(posedge clk) disable iff (rst)
		(hit && (req.read || req.write)) |-> !stall)
		else protocol_error("stall high during a hit");
	a_read_hit_quiet: assert property (@(posedge clk) disable iff (rst)
		(req.read && !req.write && hit) |-> (!mem_req.read && !mem_req.write))
		else protocol_error("read hit went to memory");

	function automatic logic [`CACHE_DATA_W-1:0] initial_word(input logic [`CACHE_ADDR_W-1:0] a);
		return a ^ 16'h5a5a; // memory content rule
	endfunction

	// galois lfsr stepped once per bit handed out
	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] bits;
		logic b;
		bits = '0;
		for (int k = 0; k < n; k++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b) begin
				lfsr = lfsr ^ LFSR_TAPS;
			end
			bits = {bits[30:0], b};
		end
		return bits;
	endfunction

	task automatic check_word(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			mismatches++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic protocol_error(input string what);
		other_errors++;
		$display("protocol error: %s", what);
	endtask

	task automatic print_counts();
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
	endtask

	task automatic expect_quiet(input string name);
		check_word({name, " stall"}, 16'h0, 16'(stall));
		check_word({name, " mem read"}, 16'h0, 16'(mem_req.read));
		check_word({name, " mem write"}, 16'h0, 16'(mem_req.write));
	endtask

	task automatic reset_dut();
		rst = 1'b1;
		model_valid = '0; // reset leaves every block invalid
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			expect_quiet("during reset");
		end
		rst = 1'b0;
		@(negedge clk);
		expect_quiet("after reset");
	endtask

	// one pipeline access held until stall falls and checked in its hit cycle
	task automatic access(input string name, input logic is_write, input logic [15:0] addr,
		input logic [15:0] wdata, input logic [15:0] other_raddr);
		logic [`CACHE_TAG_W-1:0] tag;
		logic [`CACHE_INDEX_W-1:0] idx;
		logic expect_miss;
		int cycles;
		int issued;
		tag = addr[15:11];
		idx = addr[10:4];
		expect_miss = !(model_valid[idx] && model_tag[idx] == tag);
		@(negedge clk);
		req.read = 1'b1; // a store also carries a load to test priority
		req.write = is_write;
		req.raddr = is_write ? other_raddr : addr;
		req.waddr = addr;
		req.wdata = wdata;
		#1; // let the lookup settle
		check_word({name, " stall in request cycle"}, 16'(expect_miss), 16'(stall));
		cycles = 0;
		issued = 0;
		while (stall && cycles < FILL_GUARD) begin
			@(negedge clk);
			#1;
			cycles++;
			if (mem_req.read) begin
				check_word({name, " fill address"}, {tag, idx, 3'(issued), 1'b0}, mem_req.addr);
				issued++;
			end
		end
		if (expect_miss) begin
			check_word({name, " fill cycles"}, 16'(FILL_CYCLES), 16'(cycles));
			check_word({name, " fill words"}, 16'(`CACHE_WORDS), 16'(issued));
		end
		check_word({name, " hit"}, 16'h1, 16'(hit));
		check_word({name, " mem read after fill"}, 16'h0, 16'(mem_req.read));
		if (is_write) begin
			check_word({name, " write strobe"}, 16'h1, 16'(mem_req.write));
			check_word({name, " write addr"}, addr, mem_req.addr);
			check_word({name, " write data"}, wdata, mem_req.wdata);
			shadow[addr[15:1]] = wdata;
			writes_expected++;
		end else begin
			check_word({name, " rdata"}, shadow[addr[15:1]], rdata);
			check_word({name, " write strobe"}, 16'h0, 16'(mem_req.write));
		end
		model_valid[idx] = 1'b1; // both loads and stores allocate
		model_tag[idx] = tag;
		@(negedge clk);
		req = '0;
		check_word({name, " write count"}, 16'(writes_expected), 16'(writes_seen));
		check_word({name, " memory word"}, shadow[addr[15:1]], u_mem.mem[addr[15:1]]);
	endtask

	task automatic run_random(input int n);
		logic [15:0] addr;
		logic [15:0] data;
		logic [15:0] other;
		logic [1:0] tag_bits;
		logic [2:0] set_bits;
		logic [3:0] offset_bits;
		logic is_write;
		for (int i = 0; i < n; i++) begin
			// 4 tags over 8 sets keeps a mix of hits, misses and evictions
			tag_bits = 2'(lfsr_take(2));
			set_bits = 3'(lfsr_take(3));
			offset_bits = 4'(lfsr_take(4));
			addr = {3'b101, tag_bits, 4'b0000, set_bits, offset_bits};
			is_write = lfsr_take(1) != 0;
			data = 16'(lfsr_take(16));
			other = 16'(lfsr_take(16));
			access($sformatf("random %0d", i), is_write, addr, data, other);
		end
	endtask

	initial begin
		rst = 1'b1;
		req = '0;
		lfsr = 32'h08e852a3;
		for (int i = 0; i < WORDS; i++) begin
			shadow[i] = initial_word(16'(i << 1));
		end
		reset_dut();

		access("cold read miss", 1'b0, 16'h1234, 16'h0, 16'h0);
		access("read hit", 1'b0, 16'h123a, 16'h0, 16'h0); // other word of the same block
		access("write hit", 1'b1, 16'h1236, 16'hbeef, 16'h0456);
		access("read after write", 1'b0, 16'h1236, 16'h0, 16'h0);

		// set 0x21 with tags 0x03 and 0x14 so each read evicts the other
		repeat (2) begin
			access("conflict a", 1'b0, 16'h1a16, 16'h0, 16'h0);
			access("conflict b", 1'b0, 16'ha216, 16'h0, 16'h0);
		end

		run_random(RANDOM_OPS);

		@(negedge clk);
		print_counts();
		if (mismatches == 0 && other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* dv/mem_model.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module mem_model
	import cache_pkg::*;
(
	input logic clk,
	input logic rst,
	input mem_req_t mem_req, // fill reads and write-through from the cache
	output mem_rsp_t mem_rsp // one valid pulse per returned word
);

	localparam int WORDS = 1 << (`CACHE_ADDR_W - 1); // word addressed, bit 0 dropped
	localparam int LAT = `CACHE_MEM_LATENCY;

	logic [`CACHE_DATA_W-1:0] mem [WORDS]; // backing store
	logic [LAT-1:0] pipe_valid; // reads in flight, oldest at the top
	logic [`CACHE_ADDR_W-2:0] pipe_addr [LAT]; // word address of each read in flight

	// word at byte address a holds a xor 5a5a
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = {i[`CACHE_ADDR_W-2:0], 1'b0} ^ 16'h5a5a;
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[LAT-2:0], mem_req.read}; // no back-pressure, one stage per cycle
		end
		pipe_addr[0] <= mem_req.addr[`CACHE_ADDR_W-1:1];
		for (int s = 1; s < LAT; s++) begin
			pipe_addr[s] <= pipe_addr[s-1];
		end
		if (!rst && mem_req.write) begin
			mem[mem_req.addr[`CACHE_ADDR_W-1:1]] <= mem_req.wdata; // store lands at this edge
		end
	end

	// data appears exactly LAT cycles after its address, in issue order
	assign mem_rsp.valid = pipe_valid[LAT-1];
	assign mem_rsp.rdata = mem[pipe_addr[LAT-1]];

endmodule

/* hw/cache_addr_decode.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_addr_decode
	import cache_pkg::*;
(
	input cache_req_t req, // pipeline request levels
	input logic busy, // fill in progress
	input meta_entry_t meta, // entry of the selected set
	output addr_fields_t fields, // split active address
	output cache_op_e op, // resolved operation
	output logic hit, // valid and tag match
	output logic miss // access without a hit, outside a fill
);

	logic [`CACHE_ADDR_W-1:0] addr; // active address
	logic tag_match; // stored tag equals request tag

	// store has priority over load
	always_comb begin
		if (req.write) begin
			op = OP_WRITE;
		end else if (req.read) begin
			op = OP_READ;
		end else begin
			op = OP_NONE;
		end
	end

	assign addr = req.write ? req.waddr : req.raddr; // store uses its own address

	assign fields = addr_fields_t'(addr); // tag | index | offset

	assign tag_match = (meta.tag == fields.tag);
	assign hit = meta.valid & tag_match; // combinational lookup

	// no new miss while the sequencer is mid-fill, the held request waits
	assign miss = (op != OP_NONE) & ~hit & ~busy;

endmodule

/* hw/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// widths of the pipeline and memory buses
`define CACHE_ADDR_W 16 // byte address
`define CACHE_DATA_W 16 // one word

// address split, tag | index | offset
`define CACHE_TAG_W 5 // addr[15:11]
`define CACHE_INDEX_W 7 // addr[10:4], 128 sets
`define CACHE_OFFSET_W 4 // addr[3:0], byte offset in block

// block geometry
`define CACHE_WORDS 8 // words per block, 16 bytes

// cycles from a read address on the memory port to its data valid pulse
// must stay below CACHE_WORDS so reads overlap during the issue phase
`define CACHE_MEM_LATENCY 4

`endif

/* hw/cache_data_array.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_data_array (
	input logic clk,
	input logic [`CACHE_INDEX_W-1:0] index, // set select
	input logic [`CACHE_OFFSET_W-1:0] offset, // byte offset, bit 0 ignored
	input logic fill_write, // word returned from memory
	input logic [`CACHE_DATA_W-1:0] fill_data, // memory read data
	input logic cpu_write, // store hit outside a fill
	input logic [`CACHE_DATA_W-1:0] cpu_data, // pipeline store data
	output logic [`CACHE_DATA_W-1:0] rdata // word at index and offset
);

	localparam int SETS = 1 << `CACHE_INDEX_W;
	localparam int WSEL_W = `CACHE_OFFSET_W - 1; // word in block
	localparam int DEPTH = SETS * `CACHE_WORDS; // 1024 words

	logic [`CACHE_DATA_W-1:0] mem [DEPTH]; // word storage
	logic [`CACHE_INDEX_W+WSEL_W-1:0] word_addr; // set and word
	logic [`CACHE_DATA_W-1:0] wr_data; // selected write data
	logic wr_en;

	assign word_addr = {index, offset[`CACHE_OFFSET_W-1:1]};

	// a store needs a hit and a fill word needs a miss, so the two never meet
	assign wr_en = fill_write | cpu_write;
	assign wr_data = fill_write ? fill_data : cpu_data;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[word_addr] <= wr_data;
		end
	end

	assign rdata = mem[word_addr]; // combinational read, hit data same cycle

endmodule

/* hw/cache_fill_fsm.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_fill_fsm
	import cache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic miss, // start a block fill
	input addr_fields_t fields, // held address of the missing request
	input mem_rsp_t mem_rsp, // returned words
	output logic busy, // fill in progress
	output logic [`CACHE_OFFSET_W-1:0] fill_offset, // data array offset of the word arriving now
	output logic write_data, // store the arriving word
	output logic write_tag, // last word in, set valid and tag
	output logic mem_read, // new word address this cycle
	output logic [`CACHE_ADDR_W-1:0] mem_read_addr // word address to memory
);

	localparam int WSEL_W = `CACHE_OFFSET_W - 1; // word select, drops the byte bit
	localparam logic [WSEL_W-1:0] LAST_WORD = WSEL_W'(`CACHE_WORDS - 1);

	fill_state_e state; // current sequencer state
	fill_state_e state_nxt;
	logic [WSEL_W-1:0] issue_cnt; // word being requested
	logic [WSEL_W-1:0] rcv_cnt; // word expected next from memory
	logic last_issue; // final word address goes out this cycle
	logic last_rcv; // final word arrives this cycle

	assign busy = (state != FILL_IDLE);
	assign mem_read = (state == FILL_ISSUE); // one address per cycle, no back-pressure

	assign last_issue = (issue_cnt == LAST_WORD);
	assign last_rcv = (rcv_cnt == LAST_WORD);

	// words come back in issue order, so a count of arrivals names the word
	assign write_data = busy & mem_rsp.valid;
	assign write_tag = write_data & last_rcv; // closes the fill
	assign fill_offset = {rcv_cnt, 1'b0};

	// outside a fill the port carries the request address for write-through
	assign mem_read_addr = mem_read ? {fields.tag, fields.index, issue_cnt, 1'b0}
		: {fields.tag, fields.index, fields.offset};

	always_comb begin
		state_nxt = state;
		case (state)
			FILL_IDLE: begin
				if (miss) begin
					state_nxt = FILL_ISSUE; // first address next cycle
				end
			end
			FILL_ISSUE: begin
				if (last_issue) begin
					state_nxt = FILL_DRAIN; // all 8 addresses out
				end
			end
			FILL_DRAIN: begin
				if (write_tag) begin
					state_nxt = FILL_IDLE; // held request hits next cycle
				end
			end
			default: begin
				state_nxt = FILL_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FILL_IDLE;
			issue_cnt <= '0;
			rcv_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == FILL_IDLE) begin
				issue_cnt <= '0; // fill always starts at word 0
				rcv_cnt <= '0;
			end else begin
				if (mem_read) begin
					issue_cnt <= issue_cnt + 1'b1;
				end
				if (write_data) begin
					rcv_cnt <= rcv_cnt + 1'b1;
				end
			end
		end
	end

endmodule

/* hw/cache_meta_array.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_meta_array
	import cache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [`CACHE_INDEX_W-1:0] index, // set select
	input logic write, // tag write at end of fill
	input logic [`CACHE_TAG_W-1:0] wtag, // tag of the filled block
	output meta_entry_t meta // entry of the selected set
);

	localparam int SETS = 1 << `CACHE_INDEX_W; // 128 sets

	logic [SETS-1:0] valid; // one bit per set, cleared by reset
	logic [`CACHE_TAG_W-1:0] tags [SETS]; // tag storage

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0; // every block invalid after reset
		end else if (write) begin
			valid[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (write) begin
			tags[index] <= wtag;
		end
	end

	// asynchronous read for the same-cycle hit check
	assign meta.valid = valid[index];
	assign meta.tag = tags[index];

endmodule

/* hw/cache_pkg.sv */
`include "cache_cfg.svh"

package cache_pkg;

	typedef enum logic [1:0] {
		OP_NONE = 2'd0, // no access this cycle
		OP_READ = 2'd1, // pipeline load
		OP_WRITE = 2'd2 // pipeline store, wins over read
	} cache_op_e;

	typedef enum logic [1:0] {
		FILL_IDLE = 2'd0, // waiting for a miss
		FILL_ISSUE = 2'd1, // one word address per cycle
		FILL_DRAIN = 2'd2 // waiting for the remaining words
	} fill_state_e;

	typedef struct packed {
		logic read; // level, held during stall
		logic write; // level, held during stall
		logic [`CACHE_ADDR_W-1:0] raddr; // load address
		logic [`CACHE_ADDR_W-1:0] waddr; // store address
		logic [`CACHE_DATA_W-1:0] wdata; // store data
	} cache_req_t;

	typedef struct packed {
		logic [`CACHE_TAG_W-1:0] tag; // msbs of the address
		logic [`CACHE_INDEX_W-1:0] index; // set select
		logic [`CACHE_OFFSET_W-1:0] offset; // byte in block, bit 0 ignored
	} addr_fields_t;

	typedef struct packed {
		logic valid; // block holds memory data
		logic [`CACHE_TAG_W-1:0] tag; // tag of the stored block
	} meta_entry_t;

	typedef struct packed {
		logic read; // new word address this cycle
		logic write; // write-through of a store hit
		logic [`CACHE_ADDR_W-1:0] addr; // fill word or store address
		logic [`CACHE_DATA_W-1:0] wdata; // store data
	} mem_req_t;

	typedef struct packed {
		logic valid; // one-cycle pulse per returned word
		logic [`CACHE_DATA_W-1:0] rdata; // returned word
	} mem_rsp_t;

endpackage

/* hw/cache_top.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_top
	import cache_pkg::*;
(
	input logic clk,
	input logic rst,
	input cache_req_t req, // pipeline request
	input mem_rsp_t mem_rsp, // memory read return
	output logic [`CACHE_DATA_W-1:0] rdata, // load data
	output logic hit, // lookup hit
	output logic stall, // hold the pipeline
	output mem_req_t mem_req // fill reads and write-through
);

	addr_fields_t fields; // split active address
	cache_op_e op;
	meta_entry_t meta; // entry of the selected set
	logic miss;
	logic busy; // sequencer mid-fill
	logic [`CACHE_OFFSET_W-1:0] fill_offset;
	logic [`CACHE_OFFSET_W-1:0] data_offset; // offset seen by the data array
	logic write_data; // fill word strobe
	logic write_tag; // end of fill
	logic mem_read;
	logic [`CACHE_ADDR_W-1:0] mem_addr;
	logic cpu_write; // store hit, goes to array and memory together

	cache_addr_decode u_decode (
		.req(req),
		.busy(busy),
		.meta(meta),
		.fields(fields),
		.op(op),
		.hit(hit),
		.miss(miss)
	);

	cache_fill_fsm u_fill (
		.clk(clk),
		.rst(rst),
		.miss(miss),
		.fields(fields),
		.mem_rsp(mem_rsp),
		.busy(busy),
		.fill_offset(fill_offset),
		.write_data(write_data),
		.write_tag(write_tag),
		.mem_read(mem_read),
		.mem_read_addr(mem_addr)
	);

	cache_meta_array u_meta (
		.clk(clk),
		.rst(rst),
		.index(fields.index),
		.write(write_tag),
		.wtag(fields.tag),
		.meta(meta)
	);

	assign data_offset = busy ? fill_offset : fields.offset; // fill word or request word
	assign cpu_write = (op == OP_WRITE) & hit & ~busy;

	cache_data_array u_data (
		.clk(clk),
		.index(fields.index),
		.offset(data_offset),
		.fill_write(write_data),
		.fill_data(mem_rsp.rdata),
		.cpu_write(cpu_write),
		.cpu_data(req.wdata),
		.rdata(rdata)
	);

	assign stall = miss | busy; // high from the miss cycle to the end of the fill

	assign mem_req.read = mem_read;
	assign mem_req.write = cpu_write; // write-through in the request cycle
	assign mem_req.addr = mem_addr;
	assign mem_req.wdata = req.wdata;

endmodule

/* sim.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_addr_decode.sv
hw/cache_fill_fsm.sv
hw/cache_meta_array.sv
hw/cache_data_array.sv
hw/cache_top.sv
dv/mem_model.sv
dv/cache_tb.sv
